/* rv_decode_cfg.svh */
`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

// data and address width
`define XLEN 32

// register file and CSR address widths
`define REG_ADDR_W 5
`define CSR_ADDR_W 12

// issued instructions remembered for forwarding
`define HIST_DEPTH 2

`endif

/* rv_isa_pkg.sv */
`include "rv_decode_cfg.svh"

package rv_isa_pkg;

  typedef logic [`XLEN-1:0]       xlen_t;
  typedef logic [31:0]            inst_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [6:0]             opcode_t;
  typedef logic [3:0]             alu_op_t;
  typedef logic [2:0]             branch_kind_t;
  typedef logic [1:0]             npc_sel_t;
  typedef logic [1:0]             wb_sel_t;
  typedef logic [1:0]             fwd_sel_t;

  // major opcodes
  localparam opcode_t OPC_LUI      = 7'b0110111;
  localparam opcode_t OPC_AUIPC    = 7'b0010111;
  localparam opcode_t OPC_JAL      = 7'b1101111;
  localparam opcode_t OPC_JALR     = 7'b1100111;
  localparam opcode_t OPC_BRANCH   = 7'b1100011;
  localparam opcode_t OPC_LOAD     = 7'b0000011;
  localparam opcode_t OPC_STORE    = 7'b0100011;
  localparam opcode_t OPC_OP_IMM   = 7'b0010011;
  localparam opcode_t OPC_OP       = 7'b0110011;
  localparam opcode_t OPC_MISC_MEM = 7'b0001111;
  localparam opcode_t OPC_SYSTEM   = 7'b1110011;

  // system instructions are matched on the whole word
  localparam inst_t INST_ECALL   = 32'h0000_0073;
  localparam inst_t INST_EBREAK  = 32'h0010_0073;
  localparam inst_t INST_MRET    = 32'h3020_0073;
  localparam inst_t INST_FENCE_I = 32'h0000_100f;

  // branch compares reuse SUB, SLT and SLTU
  localparam alu_op_t ALU_ADD     = 4'd0;
  localparam alu_op_t ALU_SUB     = 4'd1;
  localparam alu_op_t ALU_SLL     = 4'd2;
  localparam alu_op_t ALU_SLT     = 4'd3;
  localparam alu_op_t ALU_SLTU    = 4'd4;
  localparam alu_op_t ALU_XOR     = 4'd5;
  localparam alu_op_t ALU_SRL     = 4'd6;
  localparam alu_op_t ALU_SRA     = 4'd7;
  localparam alu_op_t ALU_OR      = 4'd8;
  localparam alu_op_t ALU_AND     = 4'd9;
  localparam alu_op_t ALU_CSR_SET = 4'd10;
  localparam alu_op_t ALU_CSR_CLR = 4'd11;
  localparam alu_op_t ALU_PASS_B  = 4'd12;

  localparam branch_kind_t BR_NONE = 3'd0;
  localparam branch_kind_t BR_EQ   = 3'd1;
  localparam branch_kind_t BR_NE   = 3'd2;
  localparam branch_kind_t BR_LT   = 3'd3;
  localparam branch_kind_t BR_GE   = 3'd4;
  localparam branch_kind_t BR_LTU  = 3'd5;
  localparam branch_kind_t BR_GEU  = 3'd6;

  localparam npc_sel_t NPC_SEQ    = 2'd0;
  localparam npc_sel_t NPC_JAL    = 2'd1;
  localparam npc_sel_t NPC_JALR   = 2'd2;
  localparam npc_sel_t NPC_BRANCH = 2'd3;

  // write back source
  localparam wb_sel_t WB_ALU   = 2'd0;
  localparam wb_sel_t WB_PC4   = 2'd1;
  localparam wb_sel_t WB_AUIPC = 2'd2;
  localparam wb_sel_t WB_CSR   = 2'd3;

  localparam fwd_sel_t FWD_RF  = 2'd0;
  localparam fwd_sel_t FWD_ONE = 2'd1;
  localparam fwd_sel_t FWD_TWO = 2'd2;

endpackage

/* rv_pipe_pkg.sv */
package rv_pipe_pkg;

  // one fetched instruction with its address
  typedef struct packed {
    rv_isa_pkg::xlen_t pc;
    rv_isa_pkg::inst_t inst;
  } fetch_bundle_t;

  typedef struct packed {
    rv_isa_pkg::xlen_t        pc;
    rv_isa_pkg::xlen_t        imm;
    rv_isa_pkg::reg_addr_t    rs1;
    rv_isa_pkg::reg_addr_t    rs2;
    rv_isa_pkg::reg_addr_t    rd;
    rv_isa_pkg::csr_addr_t    csr;
    rv_isa_pkg::alu_op_t      alu_op;
    logic                     op1_is_pc;
    logic                     op2_is_imm;
    rv_isa_pkg::branch_kind_t branch_kind;
    rv_isa_pkg::npc_sel_t     npc_sel;
    rv_isa_pkg::wb_sel_t      wb_sel;
    logic                     reg_wen;
    logic                     csr_wen;
    logic                     mem_ren;
    logic                     mem_wen;
    logic                     mem_byte;
    logic                     mem_half;
    logic                     mem_sext;
    logic                     ecall;
    logic                     ebreak;
    logic                     mret;
    logic                     fence_i;
    logic                     illegal;
    logic                     bubble;
  } decoded_t;

  // what execute receives
  typedef struct packed {
    decoded_t             dec;
    rv_isa_pkg::fwd_sel_t fwd_rs1;
    rv_isa_pkg::fwd_sel_t fwd_rs2;
    rv_isa_pkg::fwd_sel_t csr_fwd;
  } issue_bundle_t;

  typedef struct packed {
    rv_isa_pkg::reg_addr_t rd;
    logic                  reg_wen;
    rv_isa_pkg::csr_addr_t csr;
    logic                  csr_wen;
    logic                  is_load;
  } hist_entry_t;

endpackage

/* fetch_receiver.sv */
`timescale 1ns/1ps

module fetch_receiver (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       flush,
  input  logic                       in_req,
  output logic                       in_ack,
  input  rv_pipe_pkg::fetch_bundle_t in_bundle,
  input  logic                       pop,
  output logic                       held_valid,
  output rv_pipe_pkg::fetch_bundle_t held
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ACKED,
    S_WAIT_LOW
  } state_t;

  state_t state;
  logic   full;
  logic   capture;

  // a request is only taken while the slot is free
  assign capture = (state == S_IDLE) && in_req && !full;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (capture) begin
            state <= S_ACKED;
          end
        end
        S_ACKED: begin
          if (!in_req) begin
            state <= S_WAIT_LOW;
          end
        end
        default: begin
          // ack stays low one cycle before the next capture
          state <= S_IDLE;
        end
      endcase
    end
  end

  // flush drops the held instruction but not the handshake
  always_ff @(posedge clock) begin
    if (reset || flush) begin
      full <= 1'b0;
    end else if (capture) begin
      full <= 1'b1;
    end else if (pop) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (capture) begin
      held <= in_bundle;
    end
  end

  assign in_ack     = (state == S_ACKED);
  assign held_valid = full;

endmodule

/* inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
  input  rv_pipe_pkg::fetch_bundle_t held,
  output rv_pipe_pkg::decoded_t      decoded
);

  rv_isa_pkg::inst_t   inst;
  rv_isa_pkg::opcode_t opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic                f7_base;
  logic                f7_alt;
  logic                legal;
  rv_isa_pkg::alu_op_t arith_op;
  rv_isa_pkg::xlen_t   imm_i;
  rv_isa_pkg::xlen_t   imm_s;
  rv_isa_pkg::xlen_t   imm_b;
  rv_isa_pkg::xlen_t   imm_u;
  rv_isa_pkg::xlen_t   imm_j;

  assign inst    = held.inst;
  assign opcode  = inst[6:0];
  assign funct3  = inst[14:12];
  assign funct7  = inst[31:25];
  assign f7_base = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);

  // one immediate per format, sign taken from bit 31
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // funct3 to alu op for OP and OP-IMM, bit 30 selects SRA
  always_comb begin
    case (funct3)
      3'b000:  arith_op = rv_isa_pkg::ALU_ADD;
      3'b001:  arith_op = rv_isa_pkg::ALU_SLL;
      3'b010:  arith_op = rv_isa_pkg::ALU_SLT;
      3'b011:  arith_op = rv_isa_pkg::ALU_SLTU;
      3'b100:  arith_op = rv_isa_pkg::ALU_XOR;
      3'b101:  arith_op = f7_alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
      3'b110:  arith_op = rv_isa_pkg::ALU_OR;
      default: arith_op = rv_isa_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    decoded             = '0;
    decoded.pc          = held.pc;
    decoded.rs1         = inst[19:15];
    decoded.rs2         = inst[24:20];
    decoded.rd          = inst[11:7];
    decoded.csr         = inst[31:20];
    decoded.alu_op      = rv_isa_pkg::ALU_ADD;
    decoded.branch_kind = rv_isa_pkg::BR_NONE;
    decoded.npc_sel     = rv_isa_pkg::NPC_SEQ;
    decoded.wb_sel      = rv_isa_pkg::WB_ALU;
    legal               = 1'b1;
    case (opcode)
      rv_isa_pkg::OPC_LUI: begin
        decoded.rs1        = '0;
        decoded.imm        = imm_u;
        decoded.alu_op     = rv_isa_pkg::ALU_PASS_B;
        decoded.op2_is_imm = 1'b1;
        decoded.reg_wen    = 1'b1;
      end
      rv_isa_pkg::OPC_AUIPC: begin
        decoded.imm        = imm_u;
        decoded.op1_is_pc  = 1'b1;
        decoded.op2_is_imm = 1'b1;
        decoded.wb_sel     = rv_isa_pkg::WB_AUIPC;
        decoded.reg_wen    = 1'b1;
      end
      rv_isa_pkg::OPC_JAL: begin
        decoded.imm     = imm_j;
        decoded.npc_sel = rv_isa_pkg::NPC_JAL;
        decoded.wb_sel  = rv_isa_pkg::WB_PC4;
        decoded.reg_wen = 1'b1;
      end
      rv_isa_pkg::OPC_JALR: begin
        legal              = (funct3 == 3'b000);
        decoded.imm        = imm_i;
        decoded.op2_is_imm = 1'b1;
        decoded.npc_sel    = rv_isa_pkg::NPC_JALR;
        decoded.wb_sel     = rv_isa_pkg::WB_PC4;
        decoded.reg_wen    = 1'b1;
      end
      rv_isa_pkg::OPC_BRANCH: begin
        decoded.imm     = imm_b;
        decoded.npc_sel = rv_isa_pkg::NPC_BRANCH;
        case (funct3)
          3'b000:  decoded.branch_kind = rv_isa_pkg::BR_EQ;
          3'b001:  decoded.branch_kind = rv_isa_pkg::BR_NE;
          3'b100:  decoded.branch_kind = rv_isa_pkg::BR_LT;
          3'b101:  decoded.branch_kind = rv_isa_pkg::BR_GE;
          3'b110:  decoded.branch_kind = rv_isa_pkg::BR_LTU;
          3'b111:  decoded.branch_kind = rv_isa_pkg::BR_GEU;
          default: legal = 1'b0;
        endcase
        // eq and ne compare by subtraction
        decoded.alu_op = funct3[2] ? (funct3[1] ? rv_isa_pkg::ALU_SLTU : rv_isa_pkg::ALU_SLT)
                                   : rv_isa_pkg::ALU_SUB;
      end
      rv_isa_pkg::OPC_LOAD: begin
        legal              = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
        decoded.imm        = imm_i;
        decoded.op2_is_imm = 1'b1;
        decoded.mem_ren    = 1'b1;
        decoded.reg_wen    = 1'b1;
        decoded.mem_byte   = (funct3[1:0] == 2'b00);
        decoded.mem_half   = (funct3[1:0] == 2'b01);
        decoded.mem_sext   = !funct3[2];
      end
      rv_isa_pkg::OPC_STORE: begin
        legal              = funct3 inside {3'b000, 3'b001, 3'b010};
        decoded.imm        = imm_s;
        decoded.op2_is_imm = 1'b1;
        decoded.mem_wen    = 1'b1;
        decoded.mem_byte   = (funct3[1:0] == 2'b00);
        decoded.mem_half   = (funct3[1:0] == 2'b01);
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        // shift amounts sit in the low imm bits, the upper seven must be a valid funct7
        legal              = (funct3 == 3'b001) ? f7_base :
                             (funct3 == 3'b101) ? (f7_base || f7_alt) : 1'b1;
        decoded.imm        = imm_i;
        decoded.op2_is_imm = 1'b1;
        decoded.alu_op     = arith_op;
        decoded.reg_wen    = 1'b1;
      end
      rv_isa_pkg::OPC_OP: begin
        legal           = f7_base || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
        decoded.alu_op  = (funct3 == 3'b000 && f7_alt) ? rv_isa_pkg::ALU_SUB : arith_op;
        decoded.reg_wen = 1'b1;
      end
      rv_isa_pkg::OPC_MISC_MEM: begin
        legal           = (inst == rv_isa_pkg::INST_FENCE_I);
        decoded.fence_i = legal;
      end
      rv_isa_pkg::OPC_SYSTEM: begin
        decoded.ecall  = (inst == rv_isa_pkg::INST_ECALL);
        decoded.ebreak = (inst == rv_isa_pkg::INST_EBREAK);
        decoded.mret   = (inst == rv_isa_pkg::INST_MRET);
        case (funct3)
          3'b000: begin
            legal = decoded.ecall || decoded.ebreak || decoded.mret;
          end
          3'b001, 3'b010, 3'b011: begin
            decoded.imm     = imm_i;
            decoded.wb_sel  = rv_isa_pkg::WB_CSR;
            decoded.reg_wen = 1'b1;
            decoded.csr_wen = 1'b1;
            if (funct3 == 3'b001) begin
              // csrrw writes rs1 + x0
              decoded.rs2 = '0;
            end else begin
              decoded.alu_op = funct3[0] ? rv_isa_pkg::ALU_CSR_CLR : rv_isa_pkg::ALU_CSR_SET;
            end
          end
          default: legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase

    // an unsupported word travels on with no side effects
    if (!legal) begin
      decoded.reg_wen     = 1'b0;
      decoded.csr_wen     = 1'b0;
      decoded.mem_ren     = 1'b0;
      decoded.mem_wen     = 1'b0;
      decoded.npc_sel     = rv_isa_pkg::NPC_SEQ;
      decoded.branch_kind = rv_isa_pkg::BR_NONE;
    end
    decoded.illegal = !legal;
  end

endmodule

/* hazard_tracker.sv */
`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module hazard_tracker (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       flush,
  input  logic                       held_valid,
  input  rv_pipe_pkg::decoded_t      decoded,
  input  logic                       sender_idle,
  output logic                       issue_take,
  output logic                       pop,
  output rv_pipe_pkg::issue_bundle_t issue_bundle
);

  // entry 0 is one back, entry 1 two back
  rv_pipe_pkg::hist_entry_t hist [`HIST_DEPTH];
  rv_pipe_pkg::hist_entry_t new_entry;
  logic [`HIST_DEPTH-1:0]   rs1_hit;
  logic [`HIST_DEPTH-1:0]   rs2_hit;
  logic [`HIST_DEPTH-1:0]   csr_hit;
  logic                     load_use;

  // nearest matching entry wins
  function automatic rv_isa_pkg::fwd_sel_t fwd_pick(input logic [`HIST_DEPTH-1:0] hit);
    rv_isa_pkg::fwd_sel_t sel;
    sel = rv_isa_pkg::FWD_RF;
    if (hit[0]) begin
      sel = rv_isa_pkg::FWD_ONE;
    end else if (hit[1]) begin
      sel = rv_isa_pkg::FWD_TWO;
    end
    return sel;
  endfunction

  always_comb begin
    for (int i = 0; i < `HIST_DEPTH; i++) begin
      rs1_hit[i] = hist[i].reg_wen && (hist[i].rd == decoded.rs1) && (decoded.rs1 != '0);
      rs2_hit[i] = hist[i].reg_wen && (hist[i].rd == decoded.rs2) && (decoded.rs2 != '0);
      // only csr instructions read the old csr value
      csr_hit[i] = hist[i].csr_wen && (hist[i].csr == decoded.csr) && decoded.csr_wen;
    end
  end

  // load data is not ready for the very next instruction
  assign load_use   = hist[0].is_load && (rs1_hit[0] || rs2_hit[0]);
  assign issue_take = held_valid && sender_idle && !flush;
  assign pop        = issue_take && !load_use;

  always_comb begin
    new_entry = '0;
    if (!load_use) begin
      new_entry.rd      = decoded.rd;
      new_entry.reg_wen = decoded.reg_wen;
      new_entry.csr     = decoded.csr;
      new_entry.csr_wen = decoded.csr_wen;
      new_entry.is_load = decoded.mem_ren;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      for (int i = 0; i < `HIST_DEPTH; i++) begin
        hist[i] <= '0;
      end
    end else if (issue_take) begin
      hist[0] <= new_entry;
      for (int i = 1; i < `HIST_DEPTH; i++) begin
        hist[i] <= hist[i-1];
      end
    end
  end

  always_comb begin
    // bubble keeps the pc of the waiting instruction, everything else clear
    issue_bundle            = '0;
    issue_bundle.dec.pc     = decoded.pc;
    issue_bundle.dec.bubble = 1'b1;
    if (!load_use) begin
      issue_bundle.dec     = decoded;
      issue_bundle.fwd_rs1 = fwd_pick(rs1_hit);
      issue_bundle.fwd_rs2 = fwd_pick(rs2_hit);
      issue_bundle.csr_fwd = fwd_pick(csr_hit);
    end
  end

endmodule

/* issue_sender.sv */
`timescale 1ns/1ps

module issue_sender (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       issue_take,
  input  rv_pipe_pkg::issue_bundle_t issue_bundle,
  output logic                       sender_idle,
  output logic                       out_req,
  input  logic                       out_ack,
  output rv_pipe_pkg::issue_bundle_t out_bundle
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_WAIT_LOW
  } state_t;

  state_t state;
  logic   load;

  assign load = (state == S_IDLE) && issue_take;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (load) begin
            state <= S_REQ;
          end
        end
        S_REQ: begin
          if (out_ack) begin
            state <= S_WAIT_LOW;
          end
        end
        default: begin
          // execute has to release ack before the next transfer
          if (!out_ack) begin
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

  // only loaded when idle, so stable for the whole request phase
  always_ff @(posedge clock) begin
    if (load) begin
      out_bundle <= issue_bundle;
    end
  end

  assign out_req     = (state == S_REQ);
  assign sender_idle = (state == S_IDLE);

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       flush,
  input  logic                       in_req,
  output logic                       in_ack,
  input  rv_pipe_pkg::fetch_bundle_t in_bundle,
  output logic                       out_req,
  input  logic                       out_ack,
  output rv_pipe_pkg::issue_bundle_t out_bundle
);

  logic                       held_valid;
  rv_pipe_pkg::fetch_bundle_t held;
  rv_pipe_pkg::decoded_t      decoded;
  logic                       issue_take;
  logic                       pop;
  logic                       sender_idle;
  rv_pipe_pkg::issue_bundle_t issue_bundle;

  fetch_receiver fetch_receiver_i (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .in_req     (in_req),
    .in_ack     (in_ack),
    .in_bundle  (in_bundle),
    .pop        (pop),
    .held_valid (held_valid),
    .held       (held)
  );

  inst_decoder inst_decoder_i (
    .held    (held),
    .decoded (decoded)
  );

  hazard_tracker hazard_tracker_i (
    .clock        (clock),
    .reset        (reset),
    .flush        (flush),
    .held_valid   (held_valid),
    .decoded      (decoded),
    .sender_idle  (sender_idle),
    .issue_take   (issue_take),
    .pop          (pop),
    .issue_bundle (issue_bundle)
  );

  issue_sender issue_sender_i (
    .clock        (clock),
    .reset        (reset),
    .issue_take   (issue_take),
    .issue_bundle (issue_bundle),
    .sender_idle  (sender_idle),
    .out_req      (out_req),
    .out_ack      (out_ack),
    .out_bundle   (out_bundle)
  );

endmodule

/* tb_decode_stage.sv */
`timescale 1ns/1ps

module tb_decode_stage;

  localparam int N_RANDOM   = 60;
  localparam int N_DIRECTED = 21;
  // every instruction may cost a bubble and each transaction gets 20 cycles
  localparam int WORST_TXN  = 2 * (N_RANDOM + N_DIRECTED);
  localparam realtime TIMEOUT = WORST_TXN * 20 * 40ns;

  logic                       clock;
  logic                       reset;
  logic                       flush;
  logic                       in_req;
  logic                       in_ack;
  rv_pipe_pkg::fetch_bundle_t in_bundle;
  logic                       out_req;
  logic                       out_ack;
  rv_pipe_pkg::issue_bundle_t out_bundle;

  integer                     seed = 9976;
  int                         errors;
  int                         errors_at_test_start;
  int                         tests_passed;
  int                         tests_failed;
  int                         received;
  logic                       stall;
  logic [31:0]                pc;
  rv_pipe_pkg::issue_bundle_t exp_q[$];
  rv_pipe_pkg::issue_bundle_t exp_front;
  logic                       exp_valid;
  rv_pipe_pkg::hist_entry_t   shadow [2];

  decode_stage decode_stage_i (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .in_req     (in_req),
    .in_ack     (in_ack),
    .in_bundle  (in_bundle),
    .out_req    (out_req),
    .out_ack    (out_ack),
    .out_bundle (out_bundle)
  );

  always #20 clock = ~clock;

  a_bundle: assert property (@(posedge clock) disable iff (reset)
    $rose(out_req) |-> exp_valid && out_bundle == exp_front)
  else begin
    errors++;
    $display("ERROR %0t: bundle for pc %h is %h, expected %h", $time,
             out_bundle.dec.pc, out_bundle, exp_front);
  end

  a_stable: assert property (@(posedge clock) disable iff (reset)
    out_req && $past(out_req) |-> $stable(out_bundle))
  else begin
    errors++;
    $display("ERROR %0t: out_bundle changed while out_req was high", $time);
  end

  a_out_req_hold: assert property (@(posedge clock) disable iff (reset)
    out_req && !out_ack |=> out_req)
  else begin
    errors++;
    $display("ERROR %0t: out_req fell before out_ack was seen", $time);
  end

  a_in_ack_hold: assert property (@(posedge clock) disable iff (reset)
    in_ack && in_req |=> in_ack)
  else begin
    errors++;
    $display("ERROR %0t: in_ack fell while in_req was still high", $time);
  end

  task automatic tick();
    @(posedge clock);
    #2;
  endtask

  function automatic rv_isa_pkg::alu_op_t alu_of(input logic [2:0] f3, input logic [6:0] f7);
    case (f3)
      3'd0: return rv_isa_pkg::ALU_ADD;
      3'd1: return rv_isa_pkg::ALU_SLL;
      3'd2: return rv_isa_pkg::ALU_SLT;
      3'd3: return rv_isa_pkg::ALU_SLTU;
      3'd4: return rv_isa_pkg::ALU_XOR;
      3'd5: return f7[5] ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
      3'd6: return rv_isa_pkg::ALU_OR;
      default: return rv_isa_pkg::ALU_AND;
    endcase
  endfunction

  // expected decode, written from the ISA encoding tables
  function automatic rv_pipe_pkg::decoded_t ref_decode(input logic [31:0] a, input logic [31:0] w);
    rv_pipe_pkg::decoded_t d;
    logic [2:0]            f3;
    logic [6:0]            f7;
    logic [31:0]           ii;
    logic                  ok;
    f3 = w[14:12];
    f7 = w[31:25];
    ii = 32'($signed(w) >>> 20);
    ok = 1'b1;
    d = '0;
    d.pc = a;
    d.rs1 = w[19:15];
    d.rs2 = w[24:20];
    d.rd = w[11:7];
    d.csr = w[31:20];
    case (w[6:0])
      7'b0110111: begin
        d.rs1 = '0;
        d.imm = {w[31:12], 12'h000};
        d.alu_op = rv_isa_pkg::ALU_PASS_B;
        d.op2_is_imm = 1'b1;
        d.reg_wen = 1'b1;
      end
      7'b0010111: begin
        d.imm = {w[31:12], 12'h000};
        d.op1_is_pc = 1'b1;
        d.op2_is_imm = 1'b1;
        d.wb_sel = rv_isa_pkg::WB_AUIPC;
        d.reg_wen = 1'b1;
      end
      7'b1101111: begin
        d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        d.npc_sel = rv_isa_pkg::NPC_JAL;
        d.wb_sel = rv_isa_pkg::WB_PC4;
        d.reg_wen = 1'b1;
      end
      7'b1100111: begin
        ok = (f3 == 3'd0);
        d.imm = ii;
        d.op2_is_imm = 1'b1;
        d.npc_sel = rv_isa_pkg::NPC_JALR;
        d.wb_sel = rv_isa_pkg::WB_PC4;
        d.reg_wen = 1'b1;
      end
      7'b1100011: begin
        d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        d.npc_sel = rv_isa_pkg::NPC_BRANCH;
        d.alu_op = (f3 < 3'd4) ? rv_isa_pkg::ALU_SUB :
                   (f3 < 3'd6) ? rv_isa_pkg::ALU_SLT : rv_isa_pkg::ALU_SLTU;
        case (f3)
          3'd0: d.branch_kind = rv_isa_pkg::BR_EQ;
          3'd1: d.branch_kind = rv_isa_pkg::BR_NE;
          3'd4: d.branch_kind = rv_isa_pkg::BR_LT;
          3'd5: d.branch_kind = rv_isa_pkg::BR_GE;
          3'd6: d.branch_kind = rv_isa_pkg::BR_LTU;
          3'd7: d.branch_kind = rv_isa_pkg::BR_GEU;
          default: ok = 1'b0;
        endcase
      end
      7'b0000011: begin
        ok = (f3 != 3'd3) && (f3 < 3'd6);
        d.imm = ii;
        d.op2_is_imm = 1'b1;
        d.mem_ren = 1'b1;
        d.reg_wen = 1'b1;
        d.mem_byte = (f3 == 3'd0) || (f3 == 3'd4);
        d.mem_half = (f3 == 3'd1) || (f3 == 3'd5);
        d.mem_sext = (f3 < 3'd4);
      end
      7'b0100011: begin
        ok = (f3 < 3'd3);
        d.imm = {ii[31:5], w[11:7]};
        d.op2_is_imm = 1'b1;
        d.mem_wen = 1'b1;
        d.mem_byte = (f3 == 3'd0);
        d.mem_half = (f3 == 3'd1);
      end
      7'b0010011: begin
        if (f3 == 3'd1) ok = (f7 == 7'h00);
        if (f3 == 3'd5) ok = (f7 == 7'h00) || (f7 == 7'h20);
        d.imm = ii;
        d.op2_is_imm = 1'b1;
        d.alu_op = alu_of(f3, f7);
        d.reg_wen = 1'b1;
      end
      7'b0110011: begin
        ok = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
        d.alu_op = (f3 == 3'd0 && f7 == 7'h20) ? rv_isa_pkg::ALU_SUB : alu_of(f3, f7);
        d.reg_wen = 1'b1;
      end
      7'b0001111: begin
        ok = (w == 32'h0000_100f);
        d.fence_i = ok;
      end
      7'b1110011: begin
        if (f3 == 3'd0) begin
          d.ecall = (w == 32'h0000_0073);
          d.ebreak = (w == 32'h0010_0073);
          d.mret = (w == 32'h3020_0073);
          ok = d.ecall || d.ebreak || d.mret;
        end else if (f3 < 3'd4) begin
          d.imm = ii;
          d.wb_sel = rv_isa_pkg::WB_CSR;
          d.reg_wen = 1'b1;
          d.csr_wen = 1'b1;
          d.alu_op = (f3 == 3'd1) ? rv_isa_pkg::ALU_ADD :
                     (f3 == 3'd2) ? rv_isa_pkg::ALU_CSR_SET : rv_isa_pkg::ALU_CSR_CLR;
          if (f3 == 3'd1) d.rs2 = '0;
        end else begin
          ok = 1'b0;
        end
      end
      default: ok = 1'b0;
    endcase
    if (!ok) begin
      d.reg_wen = 1'b0;
      d.csr_wen = 1'b0;
      d.mem_ren = 1'b0;
      d.mem_wen = 1'b0;
      d.npc_sel = rv_isa_pkg::NPC_SEQ;
      d.branch_kind = rv_isa_pkg::BR_NONE;
    end
    d.illegal = !ok;
    return d;
  endfunction

  function automatic rv_isa_pkg::fwd_sel_t reg_fwd(input rv_isa_pkg::reg_addr_t r);
    if (r != 0 && shadow[0].reg_wen && shadow[0].rd == r) return rv_isa_pkg::FWD_ONE;
    if (r != 0 && shadow[1].reg_wen && shadow[1].rd == r) return rv_isa_pkg::FWD_TWO;
    return rv_isa_pkg::FWD_RF;
  endfunction

  task automatic push_expected(input rv_pipe_pkg::issue_bundle_t b);
    exp_q.push_back(b);
    exp_front = exp_q[0];
    exp_valid = 1'b1;
  endtask

  // shadow history that adds a bubble ahead of a load consumer
  task automatic model_issue(input rv_pipe_pkg::decoded_t d);
    rv_pipe_pkg::issue_bundle_t b;
    rv_pipe_pkg::hist_entry_t   e;
    if (shadow[0].is_load && (reg_fwd(d.rs1) == rv_isa_pkg::FWD_ONE ||
                              reg_fwd(d.rs2) == rv_isa_pkg::FWD_ONE)) begin
      b = '0;
      b.dec.pc = d.pc;
      b.dec.bubble = 1'b1;
      push_expected(b);
      shadow[1] = shadow[0];
      shadow[0] = '0;
    end
    b = '0;
    b.dec = d;
    b.fwd_rs1 = reg_fwd(d.rs1);
    b.fwd_rs2 = reg_fwd(d.rs2);
    if (d.csr_wen && shadow[0].csr_wen && shadow[0].csr == d.csr) begin
      b.csr_fwd = rv_isa_pkg::FWD_ONE;
    end else if (d.csr_wen && shadow[1].csr_wen && shadow[1].csr == d.csr) begin
      b.csr_fwd = rv_isa_pkg::FWD_TWO;
    end
    push_expected(b);
    e = '0;
    e.rd = d.rd;
    e.reg_wen = d.reg_wen;
    e.csr = d.csr;
    e.csr_wen = d.csr_wen;
    e.is_load = d.mem_ren;
    shadow[1] = shadow[0];
    shadow[0] = e;
  endtask

  // four-phase master toward the fetch port
  task automatic send(input logic [31:0] w, input logic modeled);
    int gap;
    gap = {$random(seed)} % 4;
    repeat (gap) tick();
    if (modeled) model_issue(ref_decode(pc, w));
    in_bundle = {pc, w};
    in_req = 1'b1;
    pc = pc + 4;
    do tick(); while (!in_ack);
    in_req = 1'b0;
    do tick(); while (in_ack);
  endtask

  task automatic rand_inst(output logic [31:0] w);
    int cls;
    cls = {$random(seed)} % 10;
    w = $random(seed);
    // few registers, so dependencies show up often
    w[11:7] = {$random(seed)} % 4;
    w[19:15] = {$random(seed)} % 4;
    w[24:20] = {$random(seed)} % 4;
    case (cls)
      0: begin
        w[6:0] = 7'b0110011;
        w[31:25] = ((w[14:12] == 3'd0 || w[14:12] == 3'd5) && w[30]) ? 7'h20 : 7'h00;
      end
      1: begin
        w[6:0] = 7'b0010011;
        if (w[14:12] == 3'd1) w[31:25] = 7'h00;
        if (w[14:12] == 3'd5) w[31:25] = w[30] ? 7'h20 : 7'h00;
      end
      2: begin
        w[6:0] = 7'b0000011;
        if (w[14:12] == 3'd3 || w[14:12] > 3'd5) w[14:12] = 3'd2;
      end
      3: begin
        w[6:0] = 7'b0100011;
        w[14:12] = w[14:12] % 3;
      end
      4: w[6:0] = 7'b0110111;
      5: w[6:0] = 7'b0010111;
      6: w[6:0] = 7'b1101111;
      7: begin
        w[6:0] = 7'b1100111;
        w[14:12] = 3'd0;
      end
      8: begin
        w[6:0] = 7'b1100011;
        if (w[14:12] == 3'd2 || w[14:12] == 3'd3) w[13] = 1'b0;
      end
      default: begin
        w[6:0] = 7'b1110011;
        w[14:12] = 3'd1 + (w[14:12] % 3);
        w[31:20] = w[31] ? 12'h300 : 12'h301;
      end
    endcase
  endtask

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [4:0] rd);
    return {f7, rs2, rs1, 3'd0, rd, 7'b0110011};
  endfunction

  // execute side with random ack delay
  always begin
    int delay;
    tick();
    if (!reset && out_req && !stall) begin
      delay = {$random(seed)} % 8;
      repeat (delay) tick();
      out_ack = 1'b1;
      while (out_req) tick();
      out_ack = 1'b0;
      received++;
      if (exp_q.size() > 0) void'(exp_q.pop_front());
      exp_valid = (exp_q.size() > 0);
      if (exp_valid) exp_front = exp_q[0];
    end
  end

  // wait until both ports are quiet and every expected bundle has arrived
  task automatic drain();
    while (exp_q.size() > 0 || out_req || out_ack || in_ack) tick();
    repeat (3) tick();
  endtask

  task automatic finish_test(input string name);
    drain();
    if (errors == errors_at_test_start) begin
      tests_passed++;
      $display("test %s passed, %0d bundles so far", name, received);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - errors_at_test_start);
    end
    errors_at_test_start = errors;
  endtask

  initial begin
    #(TIMEOUT);
    $display("watchdog expired, the DUT stopped answering handshakes");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    logic [31:0] w;
    int          load_use_start;
    clock = 1'b0;
    reset = 1'b1;
    flush = 1'b0;
    in_req = 1'b0;
    in_bundle = '0;
    out_ack = 1'b0;
    stall = 1'b0;
    exp_valid = 1'b0;
    exp_front = '0;
    shadow[0] = '0;
    shadow[1] = '0;
    pc = 32'h0000_1000;
    repeat (3) tick();
    reset = 1'b0;
    tick();
    assert (!in_ack && !out_req) else begin
      errors++;
      $display("ERROR %0t: in_ack or out_req high after reset", $time);
    end

    for (int i = 0; i < N_RANDOM; i++) begin
      rand_inst(w);
      send(w, 1'b1);
    end
    finish_test("random_mix");

    send(enc_i(12'd5, 5'd0, 3'd0, 5'd1, 7'b0010011), 1'b1);
    send(enc_r(7'h00, 5'd0, 5'd1, 5'd2), 1'b1);
    send(enc_r(7'h20, 5'd2, 5'd1, 5'd3), 1'b1);
    send(enc_i(12'd1, 5'd1, 3'd0, 5'd0, 7'b0010011), 1'b1);
    send(enc_r(7'h00, 5'd0, 5'd0, 5'd4), 1'b1);
    // store whose immediate field looks like a destination x4
    send({7'd0, 5'd1, 5'd2, 3'd2, 5'd4, 7'b0100011}, 1'b1);
    send(enc_r(7'h00, 5'd4, 5'd4, 5'd4), 1'b1);
    send(enc_i(12'h300, 5'd1, 3'd1, 5'd5, 7'b1110011), 1'b1);
    send(enc_i(12'h300, 5'd0, 3'd2, 5'd6, 7'b1110011), 1'b1);
    finish_test("forwarding");

    load_use_start = received;
    send(enc_i(12'd0, 5'd1, 3'd2, 5'd7, 7'b0000011), 1'b1);
    send(enc_r(7'h00, 5'd0, 5'd7, 5'd8), 1'b1);
    send(enc_i(12'd4, 5'd1, 3'd4, 5'd9, 7'b0000011), 1'b1);
    send(enc_r(7'h00, 5'd9, 5'd0, 5'd10), 1'b1);
    drain();
    // four instructions and two bubbles
    if (received - load_use_start != 6) begin
      errors++;
      $display("ERROR %0t: load use sequence gave %0d bundles, expected 6", $time,
               received - load_use_start);
    end
    finish_test("load_use");

    send(32'h0000_0073, 1'b1);
    send(32'h0010_0073, 1'b1);
    send(32'h3020_0073, 1'b1);
    send(32'h0000_100f, 1'b1);
    send(32'hffff_ffff, 1'b1);
    finish_test("system");

    // first instruction parks in the sender, second stays in the slot
    stall = 1'b1;
    send(enc_i(12'd3, 5'd0, 3'd0, 5'd1, 7'b0010011), 1'b1);
    send(enc_r(7'h00, 5'd1, 5'd1, 5'd2), 1'b0);
    tick();
    flush = 1'b1;
    tick();
    flush = 1'b0;
    shadow[0] = '0;
    shadow[1] = '0;
    stall = 1'b0;
    send(enc_r(7'h00, 5'd1, 5'd1, 5'd3), 1'b1);
    finish_test("flush");

    $display("tests passed %0d failed %0d, bundles %0d, errors %0d",
             tests_passed, tests_failed, received, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
fetch_receiver.sv
inst_decoder.sv
hazard_tracker.sv
issue_sender.sv
decode_stage.sv
tb_decode_stage.sv

/* Bender.yml */
package:
  name: rv_decode_stage

sources:
  - include_dirs:
      - .
    files:
      - rv_isa_pkg.sv
      - rv_pipe_pkg.sv
      - fetch_receiver.sv
      - inst_decoder.sv
      - hazard_tracker.sv
      - issue_sender.sv
      - decode_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_decode_stage.sv
